// File: Makefile
# Verilator build and run of the uart host link testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_host_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: host_cmd_if.sv
// request and response interfaces between io handler and register master
`timescale 1ns/1ps

// one parsed frame word toward the master
interface host_req_if;
  logic [31:0] command;
  logic [31:0] address;
  logic [31:0] data;
  logic [31:0] count;
  // master can take a request
  logic        ready;
  // one cycle pulse per data word
  logic        strobe;

  modport handler (output command, address, data, count, strobe, input ready);
  modport master  (input command, address, data, count, strobe, output ready);
endinterface

// one response word back toward the serializer
interface host_rsp_if;
  logic [31:0] status;
  logic [31:0] address;
  logic [31:0] data;
  logic [31:0] count;
  // pulse, only while ready is high
  logic        en;
  // serializer can capture a word
  logic        ready;

  modport handler (input status, address, data, count, en, output ready);
  modport master  (output status, address, data, count, en, input ready);
endinterface

// File: link_proto_pkg.sv
// host protocol package with frame bytes, command and status codes, field sizes
package link_proto_pkg;

  // frame start bytes
  localparam logic [7:0] ID_BYTE = 8'hCD;
  localparam logic [7:0] ID_RESP = 8'hDC;

  // command codes, low half of the command word
  localparam logic [31:0] CMD_PING  = 32'd1;
  localparam logic [31:0] CMD_WRITE = 32'd2;
  localparam logic [31:0] CMD_READ  = 32'd3;

  // response status codes
  localparam logic [31:0] STATUS_OK  = 32'h0000_0001;
  localparam logic [31:0] STATUS_ERR = 32'h8000_0000;

  // bytes per field, most significant byte first on the line
  localparam int WORD_BYTES = 4;

  // number of data words a count field stands for
  // a count of zero still moves one word
  function automatic logic [31:0] word_count(input logic [31:0] count);
    logic [31:0] n;
    if (count == 32'd0) begin
      n = 32'd1;
    end else begin
      n = count;
    end
    return n;
  endfunction

endpackage

// File: project.f
uart_line_pkg.sv
link_proto_pkg.sv
host_cmd_if.sv
uart_rx.sv
uart_tx.sv
uart_io_handler.sv
reg_master.sv
uart_host_top.sv
tb_uart_host_top.sv

// File: reg_master.sv
// register master with register bank, command execution and response builder
`timescale 1ns/1ps

module reg_master #(
  parameter int REG_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  host_req_if.master  req,
  host_rsp_if.master  rsp
);
  import link_proto_pkg::*;

  localparam int AW = $clog2(REG_DEPTH);

  typedef enum logic [1:0] {M_IDLE, M_RSP, M_WAIT} m_state_t;

  m_state_t      state;
  logic [31:0]   regs [REG_DEPTH];
  logic [15:0]   cmd;
  logic [AW-1:0] base;
  logic [AW-1:0] rd_ptr;
  logic [31:0]   wr_idx;
  logic [31:0]   words_left;
  logic          last_write;

  assign cmd        = req.command[15:0];
  assign base       = req.address[AW-1:0];
  assign last_write = (wr_idx + 32'd1 >= word_count(req.count));
  assign req.ready  = (state == M_IDLE);
  assign rsp.en     = (state == M_RSP) && rsp.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= M_IDLE;
      wr_idx     <= '0;
      words_left <= '0;
      rd_ptr     <= '0;
      for (int i = 0; i < REG_DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        M_IDLE: begin
          if (req.strobe) begin
            // ping response unless a command below changes it
            rsp.count   <= 32'd1;
            rsp.status  <= STATUS_OK;
            rsp.address <= req.address;
            rsp.data    <= req.data;
            words_left  <= '0;
            state       <= M_RSP;
            if (cmd == CMD_WRITE[15:0]) begin
              // address wraps inside the bank
              regs[base + wr_idx[AW-1:0]] <= req.data;
              if (last_write) begin
                wr_idx <= '0;
              end else begin
                wr_idx <= wr_idx + 32'd1;
                state  <= M_IDLE;
              end
            end else if (cmd == CMD_READ[15:0]) begin
              rsp.count  <= req.count;
              rsp.data   <= regs[base];
              words_left <= word_count(req.count) - 32'd1;
              rd_ptr     <= base + 1'b1;
            end else if (cmd != CMD_PING[15:0]) begin
              rsp.status <= STATUS_ERR;
              rsp.data   <= '0;
            end
          end
        end
        M_RSP: begin
          // en is high this cycle when ready
          if (rsp.ready) begin
            if (words_left != 32'd0) begin
              rsp.data   <= regs[rd_ptr];
              rd_ptr     <= rd_ptr + 1'b1;
              words_left <= words_left - 32'd1;
              state      <= M_WAIT;
            end else begin
              state <= M_IDLE;
            end
          end
        end
        M_WAIT: begin
          // next word one cycle after ready comes back
          if (rsp.ready) begin
            state <= M_RSP;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

endmodule

// File: tb_uart_host_top.sv
// testbench for uart_host_top with serial host model, reference registers and checks
`timescale 1ns/1ps

module tb_uart_host_top;
  import link_proto_pkg::*;

  localparam int CLKS_PER_BIT = 8;
  localparam int REG_DEPTH    = 16;
  localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
  localparam int BYTE_TIMEOUT = 4 * FRAME_CLKS;
  localparam logic [31:0] SEED = 32'h3be864be;

  logic clk;
  logic rst;
  logic i_uart_rx;
  logic o_uart_tx;

  // values under check, held across one rising edge
  string       chk_name;
  logic [31:0] chk_exp;
  logic [31:0] chk_got;
  logic        chk_en;
  logic        expect_idle;

  int          value_errs;
  int          timeout_errs;
  logic [31:0] rnd;
  logic [31:0] ref_regs [REG_DEPTH];
  logic [31:0] host_words [$];
  logic [31:0] exp_words [$];
  logic [31:0] got_words [$];

  uart_host_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .REG_DEPTH    (REG_DEPTH)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .i_uart_rx (i_uart_rx),
    .o_uart_tx (o_uart_tx)
  );

  always #5 clk = ~clk;

  a_field_match: assert property (@(posedge clk) chk_en |-> (chk_got == chk_exp))
    else begin
      value_errs++;
      $display("[FAIL] %0t %s expected %h got %h", $time, chk_name, chk_exp, chk_got);
    end

  a_line_idle: assert property (@(posedge clk) expect_idle |-> o_uart_tx)
    else begin
      value_errs++;
      $display("[FAIL] %0t o_uart_tx expected 1 got 0", $time);
    end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    @(posedge clk);
    #1;
    chk_name = name;
    chk_exp  = exp;
    chk_got  = got;
    chk_en   = 1'b1;
    @(posedge clk);
    #1 chk_en = 1'b0;
  endtask

  // start bit, eight data bits lsb first, stop bit
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1 i_uart_rx = bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int i = 3; i >= 0; i--) begin
      send_byte(w[8*i +: 8]);
    end
  endtask

  // data fields come from host_words
  task automatic send_frame(input logic [31:0] count, input logic [31:0] cmd,
                            input logic [31:0] addr);
    send_byte(ID_BYTE);
    send_word(count);
    send_word(cmd);
    send_word(addr);
    foreach (host_words[i]) begin
      send_word(host_words[i]);
    end
  endtask

  task automatic read_byte(output logic [7:0] b);
    int waited;
    b = 8'h00;
    waited = 0;
    while ((o_uart_tx !== 1'b0) && (waited < BYTE_TIMEOUT)) begin
      @(negedge clk);
      waited++;
    end
    if (o_uart_tx !== 1'b0) begin
      timeout_errs++;
      $display("timeout at %0t: no start bit seen on o_uart_tx", $time);
      return;
    end
    // middle of the start bit, then one bit period per sample
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b[i] = o_uart_tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic read_word(output logic [31:0] w);
    logic [7:0] b;
    w = '0;
    for (int i = 0; i < 4; i++) begin
      read_byte(b);
      w = {w[23:0], b};
    end
  endtask

  // whole frame is decoded before any check so no byte is missed
  task automatic check_response(input logic [31:0] exp_count, input logic [31:0] exp_status,
                                input logic [31:0] exp_addr);
    logic [7:0]  id;
    logic [31:0] cnt;
    logic [31:0] status;
    logic [31:0] addr;
    logic [31:0] w;
    int          n;
    got_words.delete();
    read_byte(id);
    read_word(cnt);
    read_word(status);
    read_word(addr);
    n = (exp_count == 32'd0) ? 1 : int'(exp_count);
    for (int i = 0; i < n; i++) begin
      read_word(w);
      got_words.push_back(w);
    end
    check_field("rsp_id", {24'h0, ID_RESP}, {24'h0, id});
    check_field("rsp_count", exp_count, cnt);
    check_field("rsp_status", exp_status, status);
    check_field("rsp_address", exp_addr, addr);
    for (int i = 0; i < n; i++) begin
      check_field($sformatf("rsp_data[%0d]", i), exp_words[i], got_words[i]);
    end
  endtask

  task automatic ping_check(input logic [31:0] addr, input logic [31:0] data);
    host_words.delete();
    host_words.push_back(data);
    exp_words.delete();
    exp_words.push_back(data);
    send_frame(32'd1, CMD_PING, addr);
    check_response(32'd1, STATUS_OK, addr);
  endtask

  task automatic read_check(input logic [31:0] count, input logic [31:0] addr);
    int n;
    n = (count == 32'd0) ? 1 : int'(count);
    host_words.delete();
    host_words.push_back(32'h0);
    exp_words.delete();
    for (int i = 0; i < n; i++) begin
      exp_words.push_back(ref_regs[(int'(addr) + i) % REG_DEPTH]);
    end
    send_frame(count, CMD_READ, addr);
    check_response(count, STATUS_OK, addr);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    i_uart_rx    = 1'b1;
    chk_en       = 1'b0;
    chk_exp      = '0;
    chk_got      = '0;
    expect_idle  = 1'b0;
    value_errs   = 0;
    timeout_errs = 0;
    rnd          = SEED;
    for (int i = 0; i < REG_DEPTH; i++) begin
      ref_regs[i] = '0;
    end
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;

    // quiet line after reset
    expect_idle = 1'b1;
    repeat (100) @(posedge clk);
    #1 expect_idle = 1'b0;

    ping_check(32'h0000_0123, 32'hA5A5_5A5A);

    // four words from address 14 wrap to 0 and 1
    host_words.delete();
    for (int i = 0; i < 4; i++) begin
      rnd = lcg_next(rnd);
      host_words.push_back(rnd);
      ref_regs[(14 + i) % REG_DEPTH] = rnd;
    end
    exp_words.delete();
    exp_words.push_back(host_words[3]);
    send_frame(32'd4, CMD_WRITE, 32'd14);
    check_response(32'd1, STATUS_OK, 32'd14);
    read_check(32'd4, 32'd14);

    // count 0 moves a single word and nothing after it
    read_check(32'd0, 32'd15);
    expect_idle = 1'b1;
    repeat (2 * FRAME_CLKS) @(posedge clk);
    #1 expect_idle = 1'b0;
    read_check(32'd1, 32'd15);

    // unknown command
    rnd = lcg_next(rnd);
    host_words.delete();
    host_words.push_back(rnd);
    exp_words.delete();
    exp_words.push_back(32'h0);
    send_frame(32'd1, 32'd7, 32'd5);
    check_response(32'd1, STATUS_ERR, 32'd5);

    // stray byte ahead of the frame start
    send_byte(8'h5A);
    rnd = lcg_next(rnd);
    ping_check(32'h0000_0009, rnd);

    $display("value errors %0d, timeouts %0d", value_errs, timeout_errs);
    if ((value_errs == 0) && (timeout_errs == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: uart_host_top.sv
// top level of the uart host link, io handler joined to the register master
`timescale 1ns/1ps

module uart_host_top #(
  parameter int CLKS_PER_BIT = 16,
  parameter int REG_DEPTH    = 16
) (
  input  logic clk,
  input  logic rst,
  // serial line from the host
  input  logic i_uart_rx,
  // serial line to the host
  output logic o_uart_tx
);

  host_req_if req_bus ();
  host_rsp_if rsp_bus ();

  uart_io_handler #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_handler (
    .clk       (clk),
    .rst       (rst),
    .i_uart_rx (i_uart_rx),
    .o_uart_tx (o_uart_tx),
    .req       (req_bus.handler),
    .rsp       (rsp_bus.handler)
  );

  reg_master #(
    .REG_DEPTH (REG_DEPTH)
  ) u_master (
    .clk (clk),
    .rst (rst),
    .req (req_bus.master),
    .rsp (rsp_bus.master)
  );

endmodule

// File: uart_io_handler.sv
// uart io handler with host frame parser and response serializer
`timescale 1ns/1ps

module uart_io_handler #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         i_uart_rx,
  output logic         o_uart_tx,
  host_req_if.handler  req,
  host_rsp_if.handler  rsp
);
  import link_proto_pkg::*;

  localparam int BCW = $clog2(WORD_BYTES);
  localparam int HDR_BYTES = 4 * WORD_BYTES;
  localparam int OLW = $clog2(HDR_BYTES + 1);

  typedef enum logic [2:0] {IN_IDLE, IN_COUNT, IN_CMD, IN_ADDR, IN_DATA, IN_SEND} in_state_t;
  typedef enum logic [1:0] {OUT_IDLE, OUT_BYTES, OUT_WAIT} out_state_t;

  logic [7:0]     rx_byte;
  logic           rx_valid;
  logic [7:0]     tx_byte;
  logic           tx_start;
  logic           tx_busy;

  in_state_t      in_state;
  logic [BCW-1:0] in_bytes;
  logic [31:0]    word_idx;
  logic           last_byte;
  logic           more_words;

  out_state_t     out_state;
  logic [127:0]   out_sr;
  logic [OLW-1:0] out_left;
  logic [31:0]    words_left;

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clk     (clk),
    .rst     (rst),
    .i_rx    (i_uart_rx),
    .o_data  (rx_byte),
    .o_valid (rx_valid)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk     (clk),
    .rst     (rst),
    .i_start (tx_start),
    .i_data  (tx_byte),
    .o_tx    (o_uart_tx),
    .o_busy  (tx_busy)
  );

  assign last_byte  = rx_valid && (in_bytes == BCW'(WORD_BYTES - 1));
  // further data fields follow only for a multi-word write
  assign more_words = (req.command[15:0] == CMD_WRITE[15:0]) &&
                      (word_idx + 32'd1 < word_count(req.count));

  // frame parser
  always_ff @(posedge clk) begin
    req.strobe <= 1'b0;
    if (rst) begin
      in_state <= IN_IDLE;
      in_bytes <= '0;
      word_idx <= '0;
    end else begin
      case (in_state)
        IN_IDLE: begin
          // anything but the id byte is dropped
          if (rx_valid && (rx_byte == ID_BYTE)) begin
            word_idx <= '0;
            in_state <= IN_COUNT;
          end
        end
        IN_COUNT: begin
          if (rx_valid) begin
            req.count <= {req.count[23:0], rx_byte};
            if (last_byte) begin
              in_state <= IN_CMD;
            end
          end
        end
        IN_CMD: begin
          if (rx_valid) begin
            req.command <= {req.command[23:0], rx_byte};
            if (last_byte) begin
              in_state <= IN_ADDR;
            end
          end
        end
        IN_ADDR: begin
          if (rx_valid) begin
            req.address <= {req.address[23:0], rx_byte};
            if (last_byte) begin
              in_state <= IN_DATA;
            end
          end
        end
        IN_DATA: begin
          if (rx_valid) begin
            req.data <= {req.data[23:0], rx_byte};
            if (last_byte && req.ready) begin
              req.strobe <= 1'b1;
              word_idx   <= word_idx + 32'd1;
              in_state   <= more_words ? IN_DATA : IN_IDLE;
            end else if (last_byte) begin
              in_state <= IN_SEND;
            end
          end
        end
        IN_SEND: begin
          // master busy, hold the word
          if (req.ready) begin
            req.strobe <= 1'b1;
            word_idx   <= word_idx + 32'd1;
            in_state   <= more_words ? IN_DATA : IN_IDLE;
          end
        end
        default: in_state <= IN_IDLE;
      endcase
      if (rx_valid && (in_state != IN_IDLE) && (in_state != IN_SEND)) begin
        in_bytes <= last_byte ? '0 : in_bytes + 1'b1;
      end
    end
  end

  // response serializer
  always_ff @(posedge clk) begin
    tx_start <= 1'b0;
    if (rst) begin
      out_state  <= OUT_IDLE;
      rsp.ready  <= 1'b1;
      out_left   <= '0;
      words_left <= '0;
    end else begin
      case (out_state)
        OUT_IDLE: begin
          if (rsp.en) begin
            rsp.ready  <= 1'b0;
            out_sr     <= {rsp.count, rsp.status, rsp.address, rsp.data};
            words_left <= word_count(rsp.count) - 32'd1;
            out_left   <= OLW'(HDR_BYTES);
            tx_byte    <= ID_RESP;
            tx_start   <= 1'b1;
            out_state  <= OUT_BYTES;
          end
        end
        OUT_BYTES: begin
          // one byte per free transmitter
          if (!tx_start && !tx_busy) begin
            if (out_left != '0) begin
              tx_byte  <= out_sr[127:120];
              out_sr   <= {out_sr[119:0], 8'h00};
              out_left <= out_left - 1'b1;
              tx_start <= 1'b1;
            end else begin
              rsp.ready <= 1'b1;
              out_state <= (words_left != 32'd0) ? OUT_WAIT : OUT_IDLE;
            end
          end
        end
        OUT_WAIT: begin
          // later read words carry only the data field
          if (rsp.en) begin
            rsp.ready      <= 1'b0;
            out_sr[127:96] <= rsp.data;
            out_left       <= OLW'(WORD_BYTES);
            words_left     <= words_left - 32'd1;
            out_state      <= OUT_BYTES;
          end
        end
        default: out_state <= OUT_IDLE;
      endcase
    end
  end

  a_strobe_pulse: assert property (@(posedge clk) disable iff (rst) req.strobe |=> !req.strobe);
  a_en_when_ready: assert property (@(posedge clk) disable iff (rst) rsp.en |-> rsp.ready);

endmodule

// File: uart_line_pkg.sv
// serial line package with frame length and receive phase type
package uart_line_pkg;

  // start bit, eight data bits, stop bit
  localparam int BITS_PER_FRAME = 10;

  // receive sampling phases
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_START,
    PH_DATA,
    PH_STOP
  } rx_phase_t;

endpackage

// File: uart_rx.sv
// uart receiver with input synchronizer and mid-bit sampling, 8N1
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_rx,
  output logic [7:0] o_data,
  output logic       o_valid
);
  import uart_line_pkg::*;

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] HALF = CW'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

  logic          rx_meta;
  logic          rx_sync;
  rx_phase_t     phase;
  logic [CW-1:0] clk_cnt;
  logic [2:0]    bit_idx;
  logic [7:0]    shreg;

  always_ff @(posedge clk) begin
    o_valid <= 1'b0;
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      phase   <= PH_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
      case (phase)
        PH_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync) begin
            phase <= PH_START;
          end
        end
        PH_START: begin
          // recheck the line in the middle of the start bit
          if (clk_cnt == HALF) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            phase   <= rx_sync ? PH_IDLE : PH_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        PH_DATA: begin
          if (clk_cnt == LAST) begin
            clk_cnt <= '0;
            // lsb first
            shreg   <= {rx_sync, shreg[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              phase <= PH_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        PH_STOP: begin
          if (clk_cnt == LAST) begin
            o_data  <= shreg;
            o_valid <= 1'b1;
            phase   <= PH_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  a_valid_one_cycle: assert property (@(posedge clk) disable iff (rst) o_valid |=> !o_valid);

endmodule

// File: uart_tx.sv
// uart transmitter, one 8N1 byte per start strobe
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_start,
  input  logic [7:0] i_data,
  output logic       o_tx,
  output logic       o_busy
);
  import uart_line_pkg::*;

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam int BW = $clog2(BITS_PER_FRAME);
  localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

  logic [CW-1:0] clk_cnt;
  logic [BW-1:0] bit_idx;
  logic [7:0]    shreg;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_tx    <= 1'b1;
      o_busy  <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (!o_busy) begin
      if (i_start) begin
        // start bit goes out right away
        o_tx    <= 1'b0;
        o_busy  <= 1'b1;
        shreg   <= i_data;
        clk_cnt <= '0;
        bit_idx <= '0;
      end
    end else if (clk_cnt == LAST) begin
      clk_cnt <= '0;
      if (bit_idx == BW'(BITS_PER_FRAME - 1)) begin
        o_busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
        o_tx    <= shreg[0];
        // ones shifted in become the stop bit
        shreg   <= {1'b1, shreg[7:1]};
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  a_idle_high: assert property (@(posedge clk) disable iff (rst) !o_busy |-> o_tx);

endmodule
